//--- verilog/sifh_pkg.sv
package sifh_pkg;

    // histogram geometry
    // bins per pixel histogram
    localparam int BIN_NUM   = 16;
    // pixels served by one engine
    localparam int PIXEL_NUM = 4;

    // acquisition pattern
    // photons per pixel in one acquisition
    localparam int DATA_NUM  = 4;
    // acquisitions per frame, so 48 photons per frame
    localparam int ACQ_NUM   = 3;

    // bank layout, pixel-major then bin
    localparam int ENTRY_NUM = PIXEL_NUM * BIN_NUM;

    // saturation value of one bin
    localparam int COUNT_MAX = 15;

    // bin address from the tdc
    typedef logic [$clog2(BIN_NUM)-1:0] bin_t;

    // pixel tag
    typedef logic [$clog2(PIXEL_NUM)-1:0] pixel_t;

    // bank entry, {pixel, bin}
    typedef logic [$clog2(ENTRY_NUM)-1:0] entry_t;

    // saturating bin count
    typedef logic [$clog2(COUNT_MAX+1)-1:0] bin_count_t;

    // readout fsm
    typedef enum logic {
        IDLE,
        SCAN
    } readout_state_t;

endpackage

//--- verilog/event_if.sv
interface event_if;

    import sifh_pkg::*;

    // one pulse per photon
    logic   ev_valid;
    // bin address of the photon
    bin_t   ev_bin;
    // pixel the photon belongs to
    pixel_t ev_pixel;
    // last photon of the frame
    logic   ev_frame_end;

    // input side produces tagged events
    modport capture (output ev_valid, output ev_bin, output ev_pixel, output ev_frame_end);

    // builder consumes them
    modport builder (input ev_valid, input ev_bin, input ev_pixel, input ev_frame_end);

endinterface

//--- verilog/bank_if.sv
interface bank_if;

    import sifh_pkg::*;

    // pulse after the banks swapped
    logic       frame_done;
    // inactive bank contents at rd_addr, combinational
    bin_count_t rd_data;
    // entry being read out
    entry_t     rd_addr;
    // zero the entry at the clock edge
    logic       rd_clr;
    // readout owns the inactive bank
    logic       busy;

    modport builder (
        output frame_done, output rd_data,
        input rd_addr, input rd_clr, input busy
    );

    modport readout (
        input frame_done, input rd_data,
        output rd_addr, output rd_clr, output busy
    );

endinterface

//--- verilog/photon_capture.sv
module photon_capture (
    input  logic            clk,
    input  logic            combin_res,
    input  logic            wr_en,
    input  sifh_pkg::bin_t  bin_addr,
    event_if.capture        ev
);

    import sifh_pkg::*;

    // nested counters, photon inside pixel inside acquisition
    logic [$clog2(DATA_NUM)-1:0] data_cnt;
    pixel_t                      pixel_cnt;
    logic [$clog2(ACQ_NUM)-1:0]  acq_cnt;

    // per-level wrap conditions
    logic data_last;
    logic pixel_last;
    logic acq_last;

    assign data_last  = (data_cnt == DATA_NUM - 1);
    assign pixel_last = (pixel_cnt == PIXEL_NUM - 1);
    assign acq_last   = (acq_cnt == ACQ_NUM - 1);

    // counters advance on every strobe
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            data_cnt  <= '0;
            pixel_cnt <= '0;
            acq_cnt   <= '0;
        end else if (wr_en) begin
            data_cnt <= data_last ? '0 : data_cnt + 1'b1;
            // carry into pixel after DATA_NUM photons
            if (data_last) begin
                pixel_cnt <= pixel_last ? '0 : pixel_cnt + 1'b1;
                // carry into acquisition after the last pixel
                if (pixel_last) begin
                    acq_cnt <= acq_last ? '0 : acq_cnt + 1'b1;
                end
            end
        end
    end

    // event strobe and frame marker, one cycle behind wr_en
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            ev.ev_valid     <= 1'b0;
            ev.ev_frame_end <= 1'b0;
        end else begin
            ev.ev_valid     <= wr_en;
            ev.ev_frame_end <= wr_en && data_last && pixel_last && acq_last;
        end
    end

    // payload, tagged with the current pixel
    always_ff @(posedge clk) begin
        if (wr_en) begin
            ev.ev_bin   <= bin_addr;
            ev.ev_pixel <= pixel_cnt;
        end
    end

    // acquisition count never reaches ACQ_NUM, its width would allow it
    a_acq_range: assert property (@(posedge clk) disable iff (!combin_res)
        acq_cnt <= ACQ_NUM - 1);

endmodule

//--- verilog/histogram_builder.sv
module histogram_builder (
    input  logic      clk,
    input  logic      combin_res,
    event_if.builder  ev,
    bank_if.builder   bank,
    output logic      frame_overrun
);

    import sifh_pkg::*;

    // two banks, indexed by bank number then entry
    bin_count_t bank_mem [2][ENTRY_NUM];

    // bank taking new photons
    logic active;

    // entry addressed by the incoming photon
    entry_t     wr_entry;
    bin_count_t cur_count;
    bin_count_t next_count;

    // frame end outcomes
    logic frame_swap;
    logic frame_lost;

    assign wr_entry = {ev.ev_pixel, ev.ev_bin};

    // read-modify-write in one cycle, so back-to-back hits both count
    assign cur_count  = bank_mem[active][wr_entry];
    // hold at the top value
    assign next_count = (cur_count == bin_count_t'(COUNT_MAX)) ?
                        cur_count : cur_count + 1'b1;

    // swap only once readout has released the other bank
    assign frame_swap = ev.ev_valid && ev.ev_frame_end && !bank.busy;
    assign frame_lost = ev.ev_valid && ev.ev_frame_end && bank.busy;

    // readout always sees the finished bank
    assign bank.rd_data = bank_mem[!active][bank.rd_addr];

    // bin memory, zeroed at reset and then entry by entry on readout
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int i = 0; i < ENTRY_NUM; i++) begin
                bank_mem[0][i] <= '0;
                bank_mem[1][i] <= '0;
            end
        end else begin
            // increment in the active bank
            if (ev.ev_valid) begin
                bank_mem[active][wr_entry] <= next_count;
            end
            // clear behind the readout, other bank so no collision
            if (bank.rd_clr) begin
                bank_mem[!active][bank.rd_addr] <= '0;
            end
        end
    end

    // bank select and frame pulse
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            active          <= 1'b0;
            bank.frame_done <= 1'b0;
        end else begin
            // last photon still lands in the old bank at this edge
            if (frame_swap) begin
                active <= !active;
            end
            bank.frame_done <= frame_swap;
        end
    end

    // sticky overrun
    // counts keep piling into the active bank meanwhile
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            frame_overrun <= 1'b0;
        end else if (frame_lost) begin
            frame_overrun <= 1'b1;
        end
    end

    // clears only come from an active scan
    a_clr_in_scan: assert property (@(posedge clk) disable iff (!combin_res)
        bank.rd_clr |-> bank.busy);

endmodule

//--- verilog/histogram_readout.sv
module histogram_readout (
    input  logic                    clk,
    input  logic                    combin_res,
    bank_if.readout                 bank,
    output logic                    hist_valid,
    output sifh_pkg::pixel_t        hist_pixel,
    output sifh_pkg::bin_t          hist_bin,
    output sifh_pkg::bin_count_t    hist_count,
    output logic                    hist_bank
);

    import sifh_pkg::*;

    readout_state_t state;

    // read address
    // runs one entry ahead of the outputs
    entry_t rd_ptr;

    // output word is the final entry
    logic scan_last;

    assign scan_last = (state == SCAN) &&
                       ({hist_pixel, hist_bin} == entry_t'(ENTRY_NUM - 1));

    // entry 0 is read in the frame_done cycle itself
    assign bank.rd_clr  = bank.frame_done || ((state == SCAN) && !scan_last);
    assign bank.rd_addr = rd_ptr;

    // bank held from frame_done through the last word
    assign bank.busy = bank.frame_done || (state == SCAN);

    // fsm, bank tag and read pointer
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state     <= IDLE;
            rd_ptr    <= '0;
            hist_bank <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (bank.frame_done) begin
                        state <= SCAN;
                    end
                end
                SCAN: begin
                    if (scan_last) begin
                        state <= IDLE;
                        // next scan reads the other bank
                        hist_bank <= !hist_bank;
                    end
                end
                default: state <= IDLE;
            endcase
            // 64 steps wrap the pointer back to 0
            if (bank.rd_clr) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // word strobe
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            hist_valid <= 1'b0;
        end else begin
            hist_valid <= bank.rd_clr;
        end
    end

    // word payload, address split into pixel and bin
    always_ff @(posedge clk) begin
        if (bank.rd_clr) begin
            {hist_pixel, hist_bin} <= rd_ptr;
            hist_count             <= bank.rd_data;
        end
    end

    // words only during a scan
    a_valid_in_scan: assert property (@(posedge clk) disable iff (!combin_res)
        (state == IDLE) |-> !hist_valid);

endmodule

//--- verilog/sifh_top.sv
module sifh_top (
    input  logic                    clk,
    input  logic                    combin_res,
    // tdc side
    input  logic                    wr_en,
    input  sifh_pkg::bin_t          bin_addr,
    // histogram stream
    output logic                    hist_valid,
    output sifh_pkg::pixel_t        hist_pixel,
    output sifh_pkg::bin_t          hist_bin,
    output sifh_pkg::bin_count_t    hist_count,
    output logic                    hist_bank,
    // sticky status
    output logic                    frame_overrun
);

    // tagged photons, capture to builder
    event_if ev_bus ();

    // frame hand-off and bank reads, builder to readout
    bank_if bank_bus ();

    // counters and tagging
    photon_capture capture_i (
        .clk        (clk),
        .combin_res (combin_res),
        .wr_en      (wr_en),
        .bin_addr   (bin_addr),
        .ev         (ev_bus.capture)
    );

    // two-bank bin memory
    histogram_builder builder_i (
        .clk           (clk),
        .combin_res    (combin_res),
        .ev            (ev_bus.builder),
        .bank          (bank_bus.builder),
        .frame_overrun (frame_overrun)
    );

    // scan, clear and stream out
    histogram_readout readout_i (
        .clk        (clk),
        .combin_res (combin_res),
        .bank       (bank_bus.readout),
        .hist_valid (hist_valid),
        .hist_pixel (hist_pixel),
        .hist_bin   (hist_bin),
        .hist_count (hist_count),
        .hist_bank  (hist_bank)
    );

endmodule

//--- verification/sifh_tb.sv
module sifh_tb;

    import sifh_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 4;
    localparam int FRAME_LEN    = DATA_NUM * PIXEL_NUM * ACQ_NUM;
    // 9 frames, up to 4 cycles per photon, one scan each, plus slack
    localparam int TIMEOUT_CYCLES = 9 * (FRAME_LEN * 4 + ENTRY_NUM) + 2000;

    logic       clk;
    logic       combin_res;
    logic       wr_en;
    bin_t       bin_addr;
    logic       hist_valid;
    pixel_t     hist_pixel;
    bin_t       hist_bin;
    bin_count_t hist_count;
    logic       hist_bank;
    logic       frame_overrun;

    integer seed;
    int     value_errs;
    int     other_errs;

    // model banks, snapshot of the bank under readout
    bin_count_t m_bank [2][ENTRY_NUM];
    bin_count_t m_scan [ENTRY_NUM];
    logic       m_active;
    logic       m_scan_bank;
    logic       m_overrun;
    // cycles left with the readout busy
    int         m_busy;
    int         m_photon;
    // photon seen at the previous edge, one stage of capture delay
    logic       p_valid;
    logic       p_end;
    int         p_entry;

    sifh_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = !clk;
    end

    task automatic check_count(input string name, input bin_count_t got, input bin_count_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("ERR %s got %h exp %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_position(input pixel_t got_pixel, input bin_t got_bin,
                                  input pixel_t exp_pixel, input bin_t exp_bin);
        if (got_pixel !== exp_pixel || got_bin !== exp_bin) begin
            value_errs++;
            $display("ERR hist_pixel/hist_bin got %h/%h exp %h/%h at %0t",
                     got_pixel, got_bin, exp_pixel, exp_bin, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errs++;
            $display("ERR %s got %h exp %h at %0t", name, got, exp, $time);
        end
    endtask

    // model, stepped at each rising edge
    always @(posedge clk) begin
        logic was_busy;
        if (!combin_res) begin
            foreach (m_bank[b, k]) m_bank[b][k] = '0;
            m_active  = 1'b0;
            m_overrun = 1'b0;
            m_busy    = 0;
            m_photon  = 0;
            p_valid   = 1'b0;
            p_end     = 1'b0;
        end else begin
            was_busy = (m_busy > 0);
            if (m_busy > 0) m_busy--;
            if (p_valid) begin
                // saturating count in the active bank
                if (m_bank[m_active][p_entry] != bin_count_t'(COUNT_MAX))
                    m_bank[m_active][p_entry] = m_bank[m_active][p_entry] + 1'b1;
                if (p_end && was_busy) begin
                    m_overrun = 1'b1;
                end else if (p_end) begin
                    // swap, the finished bank reads out and ends up cleared
                    foreach (m_scan[k]) begin
                        m_scan[k] = m_bank[m_active][k];
                        m_bank[m_active][k] = '0;
                    end
                    m_scan_bank = m_active;
                    m_active    = !m_active;
                    // frame_done cycle plus 64 words
                    m_busy      = ENTRY_NUM + 1;
                end
            end
            p_valid = wr_en;
            p_end   = wr_en && (m_photon == FRAME_LEN - 1);
            if (wr_en) begin
                p_entry  = ((m_photon / DATA_NUM) % PIXEL_NUM) * BIN_NUM + int'(bin_addr);
                m_photon = (m_photon + 1) % FRAME_LEN;
            end
        end
    end

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        int widx;
        if (combin_res) begin
            widx = ENTRY_NUM - m_busy;
            check_flag("hist_valid", hist_valid, m_busy >= 1 && m_busy <= ENTRY_NUM);
            check_flag("frame_overrun", frame_overrun, m_overrun);
            if (hist_valid && m_busy >= 1 && m_busy <= ENTRY_NUM) begin
                check_position(hist_pixel, hist_bin, pixel_t'(widx / BIN_NUM),
                               bin_t'(widx % BIN_NUM));
                check_count("hist_count", hist_count, m_scan[widx]);
                check_flag("hist_bank", hist_bank, m_scan_bank);
            end
        end
    end

    // mode 0 random bins, 1 one fixed bin, 2 one bin per pixel
    task automatic send_frame(input int mode, input bin_t fixed_bin, input int max_gap);
        int     gap;
        pixel_t pix;
        for (int i = 0; i < FRAME_LEN; i++) begin
            pix   = pixel_t'((i / DATA_NUM) % PIXEL_NUM);
            wr_en = 1'b1;
            case (mode)
                0:       bin_addr = bin_t'($random(seed));
                1:       bin_addr = fixed_bin;
                default: bin_addr = bin_t'(pix * 5 + 2);
            endcase
            @(negedge clk);
            wr_en = 1'b0;
            gap   = (max_gap > 0) ? int'($unsigned($random(seed)) % (max_gap + 1)) : 0;
            repeat (gap) @(negedge clk);
        end
    endtask

    // wait for a scan to start and finish
    task automatic wait_scan_done();
        int n;
        n = 0;
        while (!hist_valid && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (!hist_valid) begin
            other_errs++;
            $display("scan did not start within 200 cycles at %0t", $time);
        end
        n = 0;
        while (hist_valid && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (hist_valid) begin
            other_errs++;
            $display("scan did not end within 100 cycles at %0t", $time);
        end
        repeat (3) @(negedge clk);
    endtask

    initial begin
        seed       = 90;
        value_errs = 0;
        other_errs = 0;
        wr_en      = 1'b0;
        bin_addr   = '0;
        combin_res = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        combin_res = 1'b1;
        repeat (2) @(negedge clk);
        // one random frame, then three more, banks alternate
        repeat (4) begin
            send_frame(0, '0, 3);
            wait_scan_done();
        end
        // single bin, 12 hits per pixel entry
        send_frame(1, bin_t'(9), 0);
        wait_scan_done();
        // fixed bin per pixel
        send_frame(2, '0, 1);
        wait_scan_done();
        // second frame ends mid scan, third adds on and saturates
        send_frame(0, '0, 0);
        send_frame(1, bin_t'(7), 0);
        send_frame(1, bin_t'(7), 0);
        wait_scan_done();
        check_flag("frame_overrun", frame_overrun, 1'b1);
        $display("errors: %0d value, %0d other", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("errors: %0d value, %0d other", value_errs, other_errs);
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- verilog.f
verilog/sifh_pkg.sv
verilog/event_if.sv
verilog/bank_if.sv
verilog/photon_capture.sv
verilog/histogram_builder.sv
verilog/histogram_readout.sv
verilog/sifh_top.sv
verification/sifh_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the histogram engine testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module sifh_tb -o sifh_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sifh_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

printf '%s\n' "$out" | grep -q "All tests passed" || exit 1
exit 0
